/* source/fixed_point_pkg.sv */
package fixed_point_pkg;

    // operand width shared by the bus registers, the queues and the divider
    localparam int data_width = 32;

    typedef logic signed [data_width-1:0] operand_t;

    // saturation limits of a signed operand
    localparam operand_t operand_max = {1'b0, {(data_width-1){1'b1}}};
    localparam operand_t operand_min = {1'b1, {(data_width-1){1'b0}}};

    // one division request as written by the bus master
    typedef struct packed {
        operand_t dividend;
        operand_t divisor;
    } div_job_t;

    // quotient carries the fractional bits in its low part
    typedef struct packed {
        operand_t quotient;
        operand_t remainder;
        logic     divide_by_zero;
        logic     overflow;
    } div_result_t;

endpackage

/* source/wishbone_pkg.sv */
package wishbone_pkg;

    localparam int wb_address_width = 5;
    localparam int wb_data_width = 32;

    // signals driven by the bus master with adr holding a word address
    typedef struct packed {
        logic                        cyc;
        logic                        stb;
        logic                        we;
        logic [wb_address_width-1:0] adr;
        logic [wb_data_width-1:0]    dat;
    } wb_request_t;

    typedef struct packed {
        logic                     ack;
        logic                     err;
        logic [wb_data_width-1:0] dat;
    } wb_response_t;

    typedef enum logic [wb_address_width-1:0] {
        reg_dividend  = 5'd0,
        reg_divisor   = 5'd1,
        reg_status    = 5'd2,
        reg_quotient  = 5'd3,
        reg_remainder = 5'd4,
        reg_pop       = 5'd5
    } reg_address_t;

    // bit positions inside the status register
    localparam int status_command_full = 0;
    localparam int status_result_ready = 1;
    localparam int status_busy = 2;
    localparam int status_divide_by_zero = 3;
    localparam int status_overflow = 4;

endpackage

/* source/divide.sv */
`timescale 1ns/1ns

module divide #(
    parameter int core_width = 42
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  start,
    input  logic [core_width-1:0] dividend,
    input  logic [core_width-1:0] divisor,
    output logic                  done,
    output logic [core_width-1:0] quotient,
    output logic [core_width-1:0] remainder
);

    localparam int count_width = (core_width > 1) ? $clog2(core_width) : 1;

    typedef enum logic [1:0] {
        state_idle,
        state_run,
        state_done
    } state_t;

    state_t                 state;
    state_t                 state_next;
    logic [count_width-1:0] count;
    logic [count_width-1:0] count_next;

    // two guard bits keep 2*A plus or minus B from wrapping for any divisor
    logic [core_width+1:0] accumulator;
    logic [core_width+1:0] accumulator_next;
    logic [core_width+1:0] shifted;
    logic [core_width+1:0] divisor_extended;
    logic [core_width-1:0] quotient_register;
    logic [core_width-1:0] quotient_next;
    logic [core_width-1:0] divisor_register;
    logic                  last_step;

    assign divisor_extended = {2'b00, divisor_register};
    assign last_step = (count == count_width'(core_width - 1));

    always_comb begin
        state_next = state;
        count_next = count;
        accumulator_next = accumulator;
        quotient_next = quotient_register;
        shifted = {accumulator[core_width:0], quotient_register[core_width-1]};
        case (state)
            state_idle: begin
                if (start) begin
                    accumulator_next = '0;
                    quotient_next = dividend;
                    count_next = '0;
                    state_next = state_run;
                end
            end
            state_run: begin
                // the sign of the partial remainder picks add or subtract
                if (accumulator[core_width+1])
                    accumulator_next = shifted + divisor_extended;
                else
                    accumulator_next = shifted - divisor_extended;
                quotient_next = {quotient_register[core_width-2:0],
                                 ~accumulator_next[core_width+1]};
                count_next = count + 1'b1;
                if (last_step) begin
                    // single correction of a negative final remainder
                    if (accumulator_next[core_width+1])
                        accumulator_next = accumulator_next + divisor_extended;
                    state_next = state_done;
                end
            end
            state_done: begin
                state_next = state_idle;
            end
            default: begin
                state_next = state_idle;
            end
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= state_idle;
            count <= '0;
        end else begin
            state <= state_next;
            count <= count_next;
        end
    end

    always_ff @(posedge clock) begin
        accumulator <= accumulator_next;
        quotient_register <= quotient_next;
        if (state == state_idle && start)
            divisor_register <= divisor;
    end

    assign done = (state == state_done);
    assign quotient = quotient_register;
    assign remainder = accumulator[core_width-1:0];

endmodule

/* source/signed_quantized_divider.sv */
`timescale 1ns/1ns

module signed_quantized_divider
    import fixed_point_pkg::*;
#(
    parameter int quantized_bits = 10
) (
    input  logic        clock,
    input  logic        reset,
    input  div_job_t    job,
    input  logic        job_available,
    input  logic        result_room,
    output logic        job_take,
    output div_result_t result,
    output logic        result_valid,
    output logic        busy
);

    localparam int core_width = data_width + quantized_bits;

    typedef enum logic [1:0] {
        state_idle,
        state_start,
        state_wait,
        state_output
    } state_t;

    state_t                state;
    logic [data_width-1:0] dividend_magnitude;
    logic [data_width-1:0] divisor_magnitude;
    logic [data_width-1:0] remainder_magnitude;
    logic                  dividend_negative;
    logic                  quotient_negative;
    logic                  divisor_zero;
    logic                  core_done;
    logic [core_width-1:0] core_dividend;
    logic [core_width-1:0] core_divisor;
    logic [core_width-1:0] core_quotient;
    logic [core_width-1:0] core_remainder;
    logic [core_width-1:0] quotient_limit;
    logic                  quotient_overflow;
    operand_t              quotient_signed;
    operand_t              remainder_signed;

    assign job_take = (state == state_idle) && job_available && result_room;
    assign result_valid = (state == state_output);
    assign busy = (state != state_idle);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= state_idle;
        end else begin
            case (state)
                state_idle:   if (job_take) state <= state_start;
                state_start:  state <= state_wait;
                state_wait:   if (core_done) state <= state_output;
                default:      state <= state_idle;
            endcase
        end
    end

    // input stage works on magnitudes and remembers the signs
    always_ff @(posedge clock) begin
        if (job_take) begin
            dividend_magnitude <= job.dividend[data_width-1] ? unsigned'(-job.dividend)
                                                              : unsigned'(job.dividend);
            divisor_magnitude <= job.divisor[data_width-1] ? unsigned'(-job.divisor)
                                                            : unsigned'(job.divisor);
            dividend_negative <= job.dividend[data_width-1];
            quotient_negative <= job.dividend[data_width-1] ^ job.divisor[data_width-1];
            divisor_zero <= (job.divisor == '0);
        end
    end

    assign core_dividend = core_width'(dividend_magnitude) << quantized_bits;
    assign core_divisor = core_width'(divisor_magnitude);

    divide #(
        .core_width(core_width)
    ) core (
        .clock(clock),
        .reset(reset),
        .start(state == state_start),
        .dividend(core_dividend),
        .divisor(core_divisor),
        .done(core_done),
        .quotient(core_quotient),
        .remainder(core_remainder)
    );

    // a negative quotient may reach one unit further than a positive one
    assign quotient_limit = core_width'(unsigned'(quotient_negative ? operand_min : operand_max));
    assign quotient_overflow = (core_quotient > quotient_limit);

    assign remainder_magnitude = core_remainder[data_width-1:0];
    assign quotient_signed = quotient_negative ? -operand_t'(core_quotient[data_width-1:0])
                                               : operand_t'(core_quotient[data_width-1:0]);
    assign remainder_signed = dividend_negative ? -operand_t'(remainder_magnitude)
                                                : operand_t'(remainder_magnitude);

    always_ff @(posedge clock) begin
        if (state == state_wait && core_done) begin
            result.divide_by_zero <= divisor_zero;
            result.overflow <= !divisor_zero && quotient_overflow;
            if (divisor_zero) begin
                result.quotient <= dividend_negative ? operand_min : operand_max;
                result.remainder <= '0;
            end else if (quotient_overflow) begin
                result.quotient <= quotient_negative ? operand_min : operand_max;
                result.remainder <= remainder_signed;
            end else begin
                result.quotient <= quotient_signed;
                result.remainder <= remainder_signed;
            end
        end
    end

endmodule

/* source/job_queue.sv */
`timescale 1ns/1ns

module job_queue #(
    parameter int depth = 4,
    parameter type payload_t = logic
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     push,
    input  logic     pop,
    input  payload_t push_data,
    output payload_t head,
    output logic     full,
    output logic     empty
);

    localparam int pointer_width = (depth > 1) ? $clog2(depth) : 1;
    localparam int count_width = $clog2(depth + 1);

    payload_t                 storage [depth];
    logic [pointer_width-1:0] write_pointer;
    logic [pointer_width-1:0] read_pointer;
    logic [count_width-1:0]   count;
    logic                     write_enable;
    logic                     read_enable;

    assign full = (count == count_width'(depth));
    assign empty = (count == '0);
    assign write_enable = push && !full;
    assign read_enable = pop && !empty;
    assign head = storage[read_pointer];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            write_pointer <= '0;
            read_pointer <= '0;
            count <= '0;
        end else begin
            if (write_enable)
                write_pointer <= (write_pointer == pointer_width'(depth - 1)) ? '0
                                                                               : write_pointer + 1'b1;
            if (read_enable)
                read_pointer <= (read_pointer == pointer_width'(depth - 1)) ? '0
                                                                             : read_pointer + 1'b1;
            // simultaneous push and pop leaves the count unchanged
            if (write_enable && !read_enable)
                count <= count + 1'b1;
            else if (read_enable && !write_enable)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (write_enable)
            storage[write_pointer] <= push_data;
    end

endmodule

/* source/divider_wb_slave.sv */
`timescale 1ns/1ns

module divider_wb_slave
    import fixed_point_pkg::*;
    import wishbone_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  wb_request_t  bus_request,
    output wb_response_t bus_response,
    output logic         job_push,
    output div_job_t     job,
    input  logic         command_full,
    input  logic         result_empty,
    input  logic         busy,
    input  div_result_t  result_head,
    output logic         result_pop
);

    reg_address_t             address;
    logic                     request_new;
    logic                     access_ok;
    logic                     write_dividend;
    logic                     write_divisor;
    logic                     write_pop;
    logic [wb_data_width-1:0] read_word;
    logic [wb_data_width-1:0] status_word;
    logic                     ack_q;
    logic                     err_q;
    logic [wb_data_width-1:0] read_data_q;
    operand_t                 dividend_q;
    operand_t                 divisor_q;

    assign address = reg_address_t'(bus_request.adr);

    // a cycle still held by the master during its response is not a new request
    assign request_new = bus_request.cyc && bus_request.stb && !ack_q && !err_q;

    always_comb begin
        status_word = '0;
        status_word[status_command_full] = command_full;
        status_word[status_result_ready] = !result_empty;
        status_word[status_busy] = busy;
        status_word[status_divide_by_zero] = !result_empty && result_head.divide_by_zero;
        status_word[status_overflow] = !result_empty && result_head.overflow;
    end

    always_comb begin
        access_ok = 1'b0;
        write_dividend = 1'b0;
        write_divisor = 1'b0;
        write_pop = 1'b0;
        read_word = '0;
        case (address)
            reg_dividend: begin
                access_ok = bus_request.we;
                write_dividend = bus_request.we;
            end
            reg_divisor: begin
                access_ok = bus_request.we && !command_full;
                write_divisor = access_ok;
            end
            reg_status: begin
                access_ok = !bus_request.we;
                read_word = status_word;
            end
            reg_quotient: begin
                access_ok = !bus_request.we && !result_empty;
                read_word = result_head.quotient;
            end
            reg_remainder: begin
                access_ok = !bus_request.we && !result_empty;
                read_word = result_head.remainder;
            end
            reg_pop: begin
                access_ok = bus_request.we;
                write_pop = bus_request.we;
            end
            default: begin
                access_ok = 1'b0;
            end
        endcase
    end

    // queue side effects are registered so they coincide with the ack cycle
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            ack_q <= 1'b0;
            err_q <= 1'b0;
            job_push <= 1'b0;
            result_pop <= 1'b0;
        end else begin
            ack_q <= request_new && access_ok;
            err_q <= request_new && !access_ok;
            job_push <= request_new && write_divisor;
            result_pop <= request_new && write_pop;
        end
    end

    always_ff @(posedge clock) begin
        if (request_new)
            read_data_q <= read_word;
        if (request_new && write_dividend)
            dividend_q <= operand_t'(bus_request.dat);
        if (request_new && write_divisor)
            divisor_q <= operand_t'(bus_request.dat);
    end

    assign bus_response = '{ack: ack_q, err: err_q, dat: read_data_q};
    assign job = '{dividend: dividend_q, divisor: divisor_q};

endmodule

/* source/quantized_divider_top.sv */
`timescale 1ns/1ns

module quantized_divider_top
    import fixed_point_pkg::*;
    import wishbone_pkg::*;
#(
    parameter int quantized_bits = 10,
    parameter int queue_depth = 4
) (
    input  logic         clock,
    input  logic         reset,
    input  wb_request_t  bus_request,
    output wb_response_t bus_response
);

    logic        command_push;
    logic        command_pop;
    logic        command_full;
    logic        command_empty;
    div_job_t    new_job;
    div_job_t    command_head;
    logic        result_push;
    logic        result_pop;
    logic        result_full;
    logic        result_empty;
    div_result_t divider_result;
    div_result_t result_head;
    logic        divider_busy;

    divider_wb_slave slave (
        .clock(clock),
        .reset(reset),
        .bus_request(bus_request),
        .bus_response(bus_response),
        .job_push(command_push),
        .job(new_job),
        .command_full(command_full),
        .result_empty(result_empty),
        .busy(divider_busy),
        .result_head(result_head),
        .result_pop(result_pop)
    );

    job_queue #(
        .depth(queue_depth),
        .payload_t(div_job_t)
    ) command_queue (
        .clock(clock),
        .reset(reset),
        .push(command_push),
        .pop(command_pop),
        .push_data(new_job),
        .head(command_head),
        .full(command_full),
        .empty(command_empty)
    );

    // only one job is in flight, so free space now means space at completion
    signed_quantized_divider #(
        .quantized_bits(quantized_bits)
    ) divider (
        .clock(clock),
        .reset(reset),
        .job(command_head),
        .job_available(!command_empty),
        .result_room(!result_full),
        .job_take(command_pop),
        .result(divider_result),
        .result_valid(result_push),
        .busy(divider_busy)
    );

    job_queue #(
        .depth(queue_depth),
        .payload_t(div_result_t)
    ) result_queue (
        .clock(clock),
        .reset(reset),
        .push(result_push),
        .pop(result_pop),
        .push_data(divider_result),
        .head(result_head),
        .full(result_full),
        .empty(result_empty)
    );

endmodule

/* verif/divider_assertions.sv */
`timescale 1ns/1ns

module divider_assertions
    import wishbone_pkg::*;
(
    input logic         clock,
    input logic         reset,
    input wb_request_t  bus_request,
    input wb_response_t bus_response,
    input logic         job_push,
    input logic         command_full
);

    int   assertion_failures = 0;
    logic responding;

    assign responding = bus_response.ack || bus_response.err;

    ack_err_exclusive: assert property (@(posedge clock) disable iff (reset)
        !(bus_response.ack && bus_response.err))
        else begin
            $error("ack and err are high in the same cycle");
            assertion_failures++;
        end

    // a response may only answer a request that was on the bus one clock earlier
    response_follows_request: assert property (@(posedge clock) disable iff (reset)
        responding |-> $past(bus_request.cyc && bus_request.stb))
        else begin
            $error("response without a preceding cyc and stb");
            assertion_failures++;
        end

    single_cycle_response: assert property (@(posedge clock) disable iff (reset)
        responding |=> !responding)
        else begin
            $error("response held for more than one cycle");
            assertion_failures++;
        end

    push_needs_room: assert property (@(posedge clock) disable iff (reset)
        job_push |-> !command_full)
        else begin
            $error("job pushed into a full command queue");
            assertion_failures++;
        end

endmodule

bind divider_wb_slave divider_assertions checks (
    .clock(clock),
    .reset(reset),
    .bus_request(bus_request),
    .bus_response(bus_response),
    .job_push(job_push),
    .command_full(command_full)
);

/* verif/divider_tb.sv */
`timescale 1ns/1ns

module divider_tb
    import fixed_point_pkg::*;
    import wishbone_pkg::*;
();

    localparam int quantized_bits = 10;
    localparam int queue_depth = 4;
    localparam int random_jobs = 50;
    // steady state holds a full command queue and a full result queue
    localparam int capacity = 2 * queue_depth;
    localparam int job_count = 4 + random_jobs + 4 + capacity + 1;
    localparam longint watchdog_ns = job_count * 60 * 100 + 20000;

    logic         clock = 1'b0;
    logic         reset;
    wb_request_t  bus_request;
    wb_response_t bus_response;
    int           error_count = 0;
    int           check_count = 0;
    logic [31:0]  random_state = 32'h7062ffa0;
    div_result_t  expected_queue [$];

    quantized_divider_top #(
        .quantized_bits(quantized_bits),
        .queue_depth(queue_depth)
    ) uut (
        .clock(clock),
        .reset(reset),
        .bus_request(bus_request),
        .bus_response(bus_response)
    );

    always #50 clock = ~clock;

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = random_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        random_state = x;
        return x;
    endfunction

    // quotient truncates toward zero and the remainder keeps the dividend sign
    function automatic div_result_t expected_result(input operand_t dividend,
                                                    input operand_t divisor);
        div_result_t expected;
        longint      a;
        longint      b;
        longint      q;
        longint      r;
        longint      limit;
        logic        negative;
        a = (dividend < 0) ? -longint'(dividend) : longint'(dividend);
        b = (divisor < 0) ? -longint'(divisor) : longint'(divisor);
        expected.divide_by_zero = (b == 0);
        expected.overflow = 1'b0;
        if (b == 0) begin
            expected.quotient = (dividend < 0) ? 32'sh80000000 : 32'sh7fffffff;
            expected.remainder = '0;
            return expected;
        end
        q = (a << quantized_bits) / b;
        r = (a << quantized_bits) % b;
        negative = (dividend < 0) != (divisor < 0);
        limit = negative ? 64'sd2147483648 : 64'sd2147483647;
        expected.remainder = operand_t'((dividend < 0) ? -r : r);
        if (q > limit) begin
            expected.overflow = 1'b1;
            expected.quotient = negative ? 32'sh80000000 : 32'sh7fffffff;
        end else begin
            expected.quotient = operand_t'(negative ? -q : q);
        end
        return expected;
    endfunction

    task automatic compare_result(input div_result_t got, input div_result_t expected,
                                  input string what);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("Fail %0t: %s gave q=%0d r=%0d flags=%b%b, expected q=%0d r=%0d flags=%b%b",
                     $time, what, got.quotient, got.remainder, got.divide_by_zero, got.overflow,
                     expected.quotient, expected.remainder, expected.divide_by_zero,
                     expected.overflow);
        end
    endtask

    task automatic compare_word(input operand_t got, input operand_t expected, input string what);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("Fail %0t: %s read %h, expected %h", $time, what, got, expected);
        end
    endtask

    task automatic compare_response(input logic acked, input logic expected_ack,
                                    input string what);
        check_count++;
        if (acked !== expected_ack) begin
            error_count++;
            $display("Fail %0t: %s answered with %s, expected %s", $time, what,
                     acked ? "ack" : "err", expected_ack ? "ack" : "err");
        end
    endtask

    task automatic bus_cycle(input logic write, input logic [4:0] address,
                             input logic [31:0] data, output logic acked,
                             output logic [31:0] read_data);
        int waited;
        waited = 0;
        @(negedge clock);
        bus_request = '{cyc: 1'b1, stb: 1'b1, we: write, adr: address, dat: data};
        do begin
            @(negedge clock);
            waited++;
        end while (!bus_response.ack && !bus_response.err && waited < 8);
        if (!bus_response.ack && !bus_response.err) begin
            error_count++;
            $display("the slave gave neither ack nor err for register %0d", address);
        end
        acked = bus_response.ack;
        read_data = bus_response.dat;
        bus_request = '0;
    endtask

    task automatic wb_write(input logic [4:0] address, input logic [31:0] data,
                            output logic acked);
        logic [31:0] ignored;
        bus_cycle(1'b1, address, data, acked, ignored);
    endtask

    task automatic wb_read(input logic [4:0] address, output logic acked,
                           output logic [31:0] data);
        bus_cycle(1'b0, address, '0, acked, data);
    endtask

    task automatic wait_result_ready(output logic [31:0] status);
        logic acked;
        int   polls;
        polls = 0;
        do begin
            wb_read(reg_status, acked, status);
            polls++;
        end while (!status[status_result_ready] && polls < 200);
        if (!status[status_result_ready]) begin
            error_count++;
            $display("no result appeared in the result queue");
        end
    endtask

    task automatic submit_job(input operand_t dividend, input operand_t divisor,
                              input logic expected_ack, input string what);
        logic acked;
        wb_write(reg_dividend, dividend, acked);
        compare_response(acked, 1'b1, {what, " dividend write"});
        wb_write(reg_divisor, divisor, acked);
        compare_response(acked, expected_ack, {what, " divisor write"});
    endtask

    task automatic collect_result(input string what);
        logic [31:0] status;
        logic [31:0] quotient;
        logic [31:0] remainder;
        logic        acked;
        div_result_t got;
        wait_result_ready(status);
        wb_read(reg_quotient, acked, quotient);
        compare_response(acked, 1'b1, {what, " quotient read"});
        wb_read(reg_remainder, acked, remainder);
        compare_response(acked, 1'b1, {what, " remainder read"});
        got = '{quotient: operand_t'(quotient), remainder: operand_t'(remainder),
                divide_by_zero: status[status_divide_by_zero],
                overflow: status[status_overflow]};
        compare_result(got, expected_queue.pop_front(), what);
        wb_write(reg_pop, '0, acked);
        compare_response(acked, 1'b1, {what, " pop"});
    endtask

    task automatic check_division(input operand_t dividend, input operand_t divisor,
                                  input string what);
        submit_job(dividend, divisor, 1'b1, what);
        expected_queue.push_back(expected_result(dividend, divisor));
        collect_result(what);
    endtask

    task automatic test_after_reset();
        logic        acked;
        logic [31:0] data;
        wb_read(reg_status, acked, data);
        compare_response(acked, 1'b1, "status read after reset");
        compare_word(operand_t'(data), '0, "status after reset");
        wb_read(reg_quotient, acked, data);
        compare_response(acked, 1'b0, "quotient read with empty result queue");
    endtask

    task automatic test_directed();
        check_division(3, 2, "3/2");
        check_division(1, 3, "1/3");
        check_division(-7, 2, "-7/2");
        check_division(5, -5, "5/-5");
    endtask

    task automatic test_random();
        logic [31:0] raw;
        operand_t    dividend;
        operand_t    divisor;
        for (int i = 0; i < random_jobs; i++) begin
            raw = next_random();
            dividend = operand_t'(raw >> 8);
            raw = next_random();
            divisor = operand_t'((raw >> (8 + raw[3:0])) | 32'd1);
            // cycle through all four sign combinations
            if (i % 2 == 1)
                dividend = -dividend;
            if ((i / 2) % 2 == 1)
                divisor = -divisor;
            check_division(dividend, divisor, "random pair");
        end
    endtask

    task automatic test_divide_by_zero();
        check_division(12345, 0, "positive over zero");
        check_division(-77, 0, "negative over zero");
    endtask

    task automatic test_overflow();
        check_division(32'sh40000000, 3, "large positive over 3");
        check_division(-32'sh40000000, 5, "large negative over 5");
    endtask

    task automatic test_back_pressure();
        logic [31:0] status;
        logic        acked;
        int          polls;
        int          settled;
        operand_t    dividend;
        operand_t    divisor;
        for (int i = 0; i < capacity; i++) begin
            polls = 0;
            do begin
                wb_read(reg_status, acked, status);
                polls++;
            end while (status[status_command_full] && polls < 200);
            if (status[status_command_full]) begin
                error_count++;
                $display("the command queue never made room for job %0d", i);
            end
            dividend = operand_t'(i * 9137 - 20000);
            divisor = operand_t'(i + 3);
            submit_job(dividend, divisor, 1'b1, "queued job");
            expected_queue.push_back(expected_result(dividend, divisor));
        end
        // both queues full and the divider idle on two reads in a row
        settled = 0;
        polls = 0;
        while (settled < 2 && polls < 400) begin
            wb_read(reg_status, acked, status);
            polls++;
            if (status[status_command_full] && status[status_result_ready] &&
                !status[status_busy])
                settled++;
            else
                settled = 0;
        end
        if (settled < 2) begin
            error_count++;
            $display("the queues never filled up under back-pressure");
        end
        submit_job(1, 1, 1'b0, "job beyond capacity");
        repeat (capacity) collect_result("queued job");
    endtask

    initial begin
        int assertion_failures;
        reset = 1'b1;
        bus_request = '0;
        repeat (8) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        test_after_reset();
        test_directed();
        test_random();
        test_divide_by_zero();
        test_overflow();
        test_back_pressure();
        assertion_failures = uut.slave.checks.assertion_failures;
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 check_count, error_count, assertion_failures);
        if (error_count == 0 && assertion_failures == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("the watchdog stopped the run before all tests finished");
        $display("Something failed");
        $finish;
    end

endmodule

/* compile.f */
source/fixed_point_pkg.sv
source/wishbone_pkg.sv
source/divide.sv
source/signed_quantized_divider.sv
source/job_queue.sv
source/divider_wb_slave.sv
source/quantized_divider_top.sv
verif/divider_assertions.sv
verif/divider_tb.sv
